// File: cpu.f
+incdir+include
hw/isa_pkg.sv
hw/datapath_pkg.sv
hw/alu.sv
hw/execute_unit.sv
hw/control_unit.sv
hw/reg_file.sv
hw/pc_unit.sv
hw/cpu.sv
tests/cpu_tb.sv

// File: hw/alu.sv
/*
 * alu
 * 8-bit pass, add, and, or and logical shift left
 */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  datapath_pkg::data_t     operand_a,
    input  datapath_pkg::data_t     operand_b,
    input  datapath_pkg::alu_func_t func,
    output datapath_pkg::data_t     alu_out
);
    import datapath_pkg::*;

    always_comb begin
        case (func)
            ALU_PASS: begin
                // loadi and mov
                alu_out = operand_b;
            end
            ALU_ADD: begin
                // carry out dropped
                alu_out = operand_a + operand_b;
            end
            ALU_AND: begin
                alu_out = operand_a & operand_b;
            end
            ALU_OR: begin
                alu_out = operand_a | operand_b;
            end
            ALU_SLL: begin
                // amount from the low three bits only
                alu_out = operand_a << operand_b[2:0];
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/control_unit.sv
/*
 * control unit
 * maps the opcode to write enable, operand selects, branch kind and alu function
 */
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  isa_pkg::opcode_t          opcode,
    output logic                      reg_write,
    output logic                      negate_src2,
    output logic                      use_imm,
    output logic                      shift_right,
    output logic                      jump,
    output isa_pkg::branch_kind_t     branch_kind,
    output datapath_pkg::alu_func_t   alu_func
);
    import isa_pkg::*;
    import datapath_pkg::*;

    always_comb begin
        // safe defaults, also used for unknown opcodes
        reg_write   = 1'b0;
        negate_src2 = 1'b0;
        use_imm     = 1'b0;
        shift_right = 1'b0;
        jump        = 1'b0;
        branch_kind = BR_NONE;
        alu_func    = ALU_PASS;

        case (opcode)
            OP_LOADI: begin
                // immediate passed straight through
                reg_write = 1'b1;
                use_imm   = 1'b1;
            end
            OP_MOV: begin
                reg_write = 1'b1;
            end
            OP_ADD: begin
                reg_write = 1'b1;
                alu_func  = ALU_ADD;
            end
            OP_SUB: begin
                // add of the negated src2
                reg_write   = 1'b1;
                negate_src2 = 1'b1;
                alu_func    = ALU_ADD;
            end
            OP_AND: begin
                reg_write = 1'b1;
                alu_func  = ALU_AND;
            end
            OP_OR: begin
                reg_write = 1'b1;
                alu_func  = ALU_OR;
            end
            OP_SLL: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_func  = ALU_SLL;
            end
            OP_SRL: begin
                // left shifter with reversal on both sides
                reg_write   = 1'b1;
                use_imm     = 1'b1;
                shift_right = 1'b1;
                alu_func    = ALU_SLL;
            end
            OP_J: begin
                jump = 1'b1;
            end
            OP_BEQ: begin
                // compare by subtraction, zero flag decides
                negate_src2 = 1'b1;
                alu_func    = ALU_ADD;
                branch_kind = BR_EQ;
            end
            OP_BNE: begin
                negate_src2 = 1'b1;
                alu_func    = ALU_ADD;
                branch_kind = BR_NE;
            end
            default: begin
                reg_write = 1'b0;
                jump      = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu.sv
/*
 * cpu
 * single-cycle 8-bit core, decode, register file, execute and pc
 */
`timescale 1ns/100ps
`default_nettype none

module cpu (
    input  logic          clk,
    input  logic          arst_n,
    input  isa_pkg::instr_t instr,
    output isa_pkg::pc_t  pc
);
    import isa_pkg::*;
    import datapath_pkg::*;

    // decode outputs
    logic         reg_write;
    logic         negate_src2;
    logic         use_imm;
    logic         shift_right;
    logic         jump;
    branch_kind_t branch_kind;
    alu_func_t    alu_func;

    // datapath
    data_t src1_data;
    data_t src2_data;
    data_t result;
    logic  zero;

    control_unit u_control_unit (
        .opcode      (opcode_t'(instr[31:24])),
        .reg_write   (reg_write),
        .negate_src2 (negate_src2),
        .use_imm     (use_imm),
        .shift_right (shift_right),
        .jump        (jump),
        .branch_kind (branch_kind),
        .alu_func    (alu_func)
    );

    // rd at 18..16, rs1 at 10..8, rs2 at 2..0
    reg_file u_reg_file (
        .clk         (clk),
        .arst_n      (arst_n),
        .write_index (instr[18:16]),
        .write_data  (result),
        .write_en    (reg_write),
        .read_index1 (instr[10:8]),
        .read_index2 (instr[2:0]),
        .read_data1  (src1_data),
        .read_data2  (src2_data)
    );

    execute_unit u_execute_unit (
        .src1        (src1_data),
        .src2        (src2_data),
        .immediate   (instr[7:0]),
        .negate_src2 (negate_src2),
        .use_imm     (use_imm),
        .shift_right (shift_right),
        .alu_func    (alu_func),
        .result      (result),
        .zero        (zero)
    );

    // jump offset shares bits with rd
    pc_unit u_pc_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .jump        (jump),
        .branch_kind (branch_kind),
        .zero        (zero),
        .offset      (jump_offset_t'(instr[23:16])),
        .pc          (pc)
    );

endmodule

`default_nettype wire

// File: hw/datapath_pkg.sv
/*
 * datapath package
 * register word, register index and alu function types
 */
`default_nettype none

`include "cpu_defines.svh"

package datapath_pkg;

    // register and alu value
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // register number
    typedef logic [`REG_INDEX_WIDTH-1:0] reg_index_t;

    // alu function select, right shift is built around ALU_SLL
    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_SLL  = 3'd4
    } alu_func_t;

endpackage

`default_nettype wire

// File: hw/execute_unit.sv
/*
 * execute unit
 * operand negate and immediate select, bit reversal around the alu, zero flag
 */
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  datapath_pkg::data_t       src1,
    input  datapath_pkg::data_t       src2,
    input  datapath_pkg::data_t       immediate,
    input  logic                      negate_src2,
    input  logic                      use_imm,
    input  logic                      shift_right,
    input  datapath_pkg::alu_func_t   alu_func,
    output datapath_pkg::data_t       result,
    output logic                      zero
);
    import datapath_pkg::*;

    data_t src2_sel;
    data_t operand_a;
    data_t operand_b;
    data_t alu_out;

    function automatic data_t reverse_bits(input data_t value);
        data_t rev;
        for (int i = 0; i < $bits(data_t); i++) begin
            rev[i] = value[$bits(data_t)-1-i];
        end
        return rev;
    endfunction

    // two's complement for sub and branch compare
    assign src2_sel  = negate_src2 ? data_t'(~src2 + 1'b1) : src2;
    assign operand_b = use_imm ? immediate : src2_sel;

    // right shift done as left shift on the reversed word
    assign operand_a = shift_right ? reverse_bits(src1) : src1;

    alu u_alu (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .func      (alu_func),
        .alu_out   (alu_out)
    );

    assign result = shift_right ? reverse_bits(alu_out) : alu_out;

    // equal operands give zero on the subtract
    assign zero = (alu_out == '0);

endmodule

`default_nettype wire

// File: hw/isa_pkg.sv
/*
 * isa package
 * opcode encoding and instruction word field types
 */
`default_nettype none

`include "cpu_defines.svh"

package isa_pkg;

    // instruction word layout
    //   31..24  opcode
    //   23..16  jump offset, signed words
    //   18..16  destination register
    //   10..8   source 1
    //    2..0   source 2
    //    7..0   immediate or shift amount

    typedef logic [`PC_WIDTH-1:0] pc_t;

    // same width as pc on this core
    typedef logic [`PC_WIDTH-1:0] instr_t;

    // eleven opcodes, values fixed for program images
    typedef enum logic [7:0] {
        OP_LOADI = 8'd0,
        OP_MOV   = 8'd1,
        OP_ADD   = 8'd2,
        OP_SUB   = 8'd3,
        OP_AND   = 8'd4,
        OP_OR    = 8'd5,
        OP_J     = 8'd6,
        OP_BEQ   = 8'd7,
        OP_BNE   = 8'd8,
        OP_SLL   = 8'd9,
        OP_SRL   = 8'd10
    } opcode_t;

    // offset in words, relative to pc+4
    typedef logic signed [7:0] jump_offset_t;

    // conditional branch flavour
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2
    } branch_kind_t;

endpackage

`default_nettype wire

// File: hw/pc_unit.sv
/*
 * pc unit
 * program counter register with pc+4, branch target and next-pc select
 */
`timescale 1ns/100ps
`default_nettype none

module pc_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 jump,
    input  isa_pkg::branch_kind_t branch_kind,
    input  logic                 zero,
    input  isa_pkg::jump_offset_t offset,
    output isa_pkg::pc_t         pc
);
    import isa_pkg::*;

    pc_t  pc_plus4;
    pc_t  offset_ext;
    pc_t  target;
    pc_t  pc_next;
    logic taken;

    // sequential address
    assign pc_plus4 = pc + 32'd4;

    // offset is signed, so the size cast sign-extends
    assign offset_ext = pc_t'(offset);

    // word offset scaled to bytes
    assign target = pc_plus4 + (offset_ext << 2);

    // jump always, branches on the compare result
    always_comb begin
        taken = jump;
        case (branch_kind)
            BR_EQ:   taken = jump | zero;
            BR_NE:   taken = jump | ~zero;
            default: taken = jump;
        endcase
    end

    assign pc_next = taken ? target : pc_plus4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
/*
 * register file
 * eight 8-bit registers, two combinational reads and one clocked write
 */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     arst_n,
    input  datapath_pkg::reg_index_t write_index,
    input  datapath_pkg::data_t      write_data,
    input  logic                     write_en,
    input  datapath_pkg::reg_index_t read_index1,
    input  datapath_pkg::reg_index_t read_index2,
    output datapath_pkg::data_t      read_data1,
    output datapath_pkg::data_t      read_data2
);
    import datapath_pkg::*;

    data_t regs [`REG_COUNT];

    // write lands on the edge, readers see it next cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_index] <= write_data;
        end
    end

    // no write-through bypass
    assign read_data1 = regs[read_index1];
    assign read_data2 = regs[read_index2];

endmodule

`default_nettype wire

// File: include/cpu_defines.svh
/*
 * cpu defines
 * widths and sizes shared by the 8-bit core and its packages
 */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// width of one register and of the alu word
`define DATA_WIDTH 8

// register file size
`define REG_COUNT 8

// index width, log2 of REG_COUNT
`define REG_INDEX_WIDTH 3

// program counter and instruction word
`define PC_WIDTH 32

`endif

// File: tests/cpu_tb.sv
/*
 * cpu testbench
 * program rom, reference model and pc assertions for the single-cycle core
 */
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;
    import isa_pkg::*;

    logic   clk;
    logic   arst_n;
    instr_t instr;
    pc_t    pc;

    // program image with one word per pc/4
    instr_t     rom [256];
    int         prog_len;
    pc_t        halt_addr;

    // reference model state
    pc_t        model_pc;
    pc_t        exp_pc;
    logic [7:0] model_regs [8];
    logic [31:0] lfsr;
    logic       checking;
    int         cycles;
    int         limit;

    cpu dut (
        .clk    (clk),
        .arst_n (arst_n),
        .instr  (instr),
        .pc     (pc)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // pc must track the model on every edge out of reset
    pc_follows_model: assert property (
        @(posedge clk) disable iff (!arst_n || !checking) pc == exp_pc)
        else report_failure($sformatf("Error: pc expected %08h actual %08h",
                                      $sampled(exp_pc), $sampled(pc)));

    // held at 0 while reset is low
    pc_held_in_reset: assert property (
        @(posedge clk) (checking && !arst_n) |-> pc == '0)
        else report_failure($sformatf("Error: pc in reset expected 00000000 actual %08h",
                                      $sampled(pc)));

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            report_failure($sformatf("Timeout: no halt after %0d cycles", limit));
        end
    end

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    function automatic instr_t enc_reg(input opcode_t op, input logic [2:0] rd,
                                       input logic [2:0] rs1, input logic [2:0] rs2);
        return {op, 5'b0, rd, 5'b0, rs1, 5'b0, rs2};
    endfunction

    function automatic instr_t enc_imm(input opcode_t op, input logic [2:0] rd,
                                       input logic [2:0] rs1, input logic [7:0] imm);
        return {op, 5'b0, rd, 5'b0, rs1, imm};
    endfunction

    // offset in words from pc+4
    function automatic instr_t enc_br(input opcode_t op, input logic [2:0] rs1,
                                      input logic [2:0] rs2, input logic [7:0] off);
        return {op, off, 5'b0, rs1, 5'b0, rs2};
    endfunction

    task automatic emit(input instr_t word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    // beq taken over a filler and then bne falls through
    task automatic emit_check(input logic [2:0] r, input logic [7:0] v);
        emit(enc_imm(OP_LOADI, 3'd7, 3'd0, v));
        emit(enc_br(OP_BEQ, r, 3'd7, 8'd1));
        emit(enc_imm(OP_LOADI, 3'd7, 3'd0, 8'hee));
        emit(enc_br(OP_BNE, r, 3'd7, 8'd1));
    endtask

    task automatic build_program();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] sh;
        // unknown opcode ff with the word address in the low byte
        for (int i = 0; i < 256; i++) begin
            rom[i] = {8'hff, 16'h0000, 8'(i)};
        end
        prog_len = 0;
        // registers all zero after reset
        emit(enc_br(OP_BNE, 3'd1, 3'd2, 8'd1));
        emit(enc_br(OP_BEQ, 3'd3, 3'd4, 8'd1));
        emit(enc_imm(OP_LOADI, 3'd7, 3'd0, 8'hee));
        for (int k = 0; k < 4; k++) begin
            take_bits(8, a);
            take_bits(8, b);
            take_bits(3, sh);
            emit(enc_imm(OP_LOADI, 3'd1, 3'd0, a));
            emit(enc_imm(OP_LOADI, 3'd2, 3'd0, b));
            emit(enc_reg(OP_ADD, 3'd3, 3'd1, 3'd2));
            emit_check(3'd3, 8'(a + b));
            emit(enc_reg(OP_SUB, 3'd4, 3'd1, 3'd2));
            emit_check(3'd4, 8'(a - b));
            emit(enc_reg(OP_AND, 3'd5, 3'd1, 3'd2));
            emit_check(3'd5, a & b);
            emit(enc_reg(OP_OR, 3'd5, 3'd1, 3'd2));
            emit_check(3'd5, a | b);
            // mov copies the src2 field
            emit(enc_reg(OP_MOV, 3'd6, 3'd0, 3'd1));
            emit_check(3'd6, a);
            emit(enc_imm(OP_SLL, 3'd3, 3'd1, sh));
            emit_check(3'd3, 8'(a << sh[2:0]));
            emit(enc_imm(OP_SRL, 3'd4, 3'd1, sh));
            emit_check(3'd4, a >> sh[2:0]);
            // order A, C, B, D
            emit(enc_br(OP_J, 3'd0, 3'd0, 8'd1));
            emit(enc_br(OP_J, 3'd0, 3'd0, 8'd1));
            emit(enc_br(OP_J, 3'd0, 3'd0, 8'hfe));
            // beq not taken and bne taken
            emit(enc_imm(OP_LOADI, 3'd2, 3'd0, a ^ 8'h01));
            emit(enc_br(OP_BEQ, 3'd1, 3'd2, 8'd1));
            emit(enc_br(OP_BNE, 3'd1, 3'd2, 8'd1));
            emit(enc_imm(OP_LOADI, 3'd7, 3'd0, 8'hee));
        end
        // self loop
        halt_addr = pc_t'(prog_len * 4);
        emit(enc_br(OP_J, 3'd0, 3'd0, 8'hff));
    endtask

    // executes the word at model_pc
    task automatic model_step();
        instr_t     w;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] imm;
        logic [2:0] rd;
        pc_t        seq;
        pc_t        tgt;
        w   = rom[model_pc[9:2]];
        rd  = w[18:16];
        a   = model_regs[w[10:8]];
        b   = model_regs[w[2:0]];
        imm = w[7:0];
        seq = model_pc + 32'd4;
        tgt = seq + ({{24{w[23]}}, w[23:16]} << 2);
        model_pc = seq;
        case (opcode_t'(w[31:24]))
            OP_LOADI: model_regs[rd] = imm;
            OP_MOV:   model_regs[rd] = b;
            OP_ADD:   model_regs[rd] = 8'(a + b);
            OP_SUB:   model_regs[rd] = 8'(a - b);
            OP_AND:   model_regs[rd] = a & b;
            OP_OR:    model_regs[rd] = a | b;
            OP_SLL:   model_regs[rd] = 8'(a << imm[2:0]);
            OP_SRL:   model_regs[rd] = a >> imm[2:0];
            OP_J:     model_pc = tgt;
            OP_BEQ:   model_pc = (a == b) ? tgt : seq;
            OP_BNE:   model_pc = (a != b) ? tgt : seq;
            default:  model_pc = seq;
        endcase
    endtask

    // one clock with inputs changed on the falling edge
    task automatic run_cycle(input logic rst);
        @(negedge clk);
        checking = 1'b1;
        arst_n   = !rst;
        if (rst) begin
            model_pc = '0;
            exp_pc   = '0;
            for (int i = 0; i < 8; i++) begin
                model_regs[i] = '0;
            end
            instr = rom[0];
        end else begin
            exp_pc = model_pc;
            instr  = rom[pc[9:2]];
            model_step();
        end
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b1;
        instr    = '0;
        checking = 1'b0;
        cycles   = 0;
        limit    = 0;
        model_pc = '0;
        exp_pc   = '0;
        lfsr     = 32'h0bac_3ce1;
        build_program();
        limit = 2 * prog_len + 20;

        repeat (5) run_cycle(1'b1);
        repeat (prog_len / 2) run_cycle(1'b0);

        // reset in the middle of the program
        run_cycle(1'b1);
        #1;
        pc_zero_on_reset: assert (pc == '0)
            else report_failure($sformatf("Error: pc after reset expected 00000000 actual %08h",
                                          pc));
        repeat (4) run_cycle(1'b1);

        // full run from a cleared register file
        while (model_pc != halt_addr) begin
            run_cycle(1'b0);
        end
        repeat (3) run_cycle(1'b0);
        @(negedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
